// ==== hdl/rs_params_pkg.sv ====
package rs_params_pkg;

    //////////////////////////////////////////////////
    // window geometry
    //////////////////////////////////////////////////

    // slots in the window
    localparam int rs_depth = 8;
    localparam int rs_slot_w = $clog2(rs_depth);

    // instructions accepted per cycle, also the result bus lane count
    localparam int dispatch_width = 2;

    // open_entries only has to reach dispatch_width
    localparam int open_w = $clog2(dispatch_width + 1);

    //////////////////////////////////////////////////
    // tags and unit counts
    //////////////////////////////////////////////////

    localparam int preg_w = 6;
    localparam int br_mask_w = 4;

    // functional unit lanes per class
    localparam int num_alu = 2;
    localparam int num_mult = 1;

endpackage

// ==== hdl/rs_types_pkg.sv ====
package rs_types_pkg;

    import rs_params_pkg::*;

    // opcode class, picks the issue path of an entry
    typedef enum logic [1:0] {
        fu_none = 2'd0,
        fu_alu  = 2'd1,
        fu_mult = 2'd2
    } fu_kind_t;

    // physical register tag
    typedef logic [preg_w-1:0] preg_t;

    // one bit per unresolved branch an instruction depends on
    typedef logic [br_mask_w-1:0] br_mask_t;

endpackage

// ==== hdl/rs_issue_select.sv ====
`timescale 1ns/1ps

module rs_issue_select
    import rs_params_pkg::*;
#(
    parameter int num_lanes = 1
)
(
    input  logic                                clock,
    input  logic                                reset,
    // ready entries of this unit class
    input  logic [rs_depth-1:0]                 request,
    // one bit per unit lane
    input  logic [num_lanes-1:0]                busy,
    // one-hot slot per lane, zero when idle
    output logic [num_lanes-1:0][rs_depth-1:0]  grant
);

    //////////////////////////////////////////////////
    // lowest index first
    //////////////////////////////////////////////////

    // requests still open after the lower lanes took theirs
    logic [rs_depth-1:0] remaining;

    // isolates the lowest set bit of remaining
    logic [rs_depth-1:0] lowest;

    always_comb begin
        remaining = request;
        lowest = '0;
        grant = '0;
        for (int lane = 0; lane < num_lanes; lane++) begin
            lowest = remaining & (~remaining + 1'b1);
            // busy lanes are skipped and leave the request for the next lane
            if (!busy[lane]) begin
                grant[lane] = lowest;
                remaining = remaining & ~lowest;
            end
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // a held unit lane gets nothing, a free one at most one requesting slot
    for (genvar lane = 0; lane < num_lanes; lane++) begin : g_lane_check
        assert property (@(posedge clock) disable iff (reset)
            (busy[lane] ? (grant[lane] == '0) : $onehot0(grant[lane])) &&
            ((grant[lane] & ~request) == '0))
            else $error("bad grant on lane %0d", lane);
    end

endmodule

// ==== hdl/rs_free_select.sv ====
`timescale 1ns/1ps

module rs_free_select
    import rs_params_pkg::*;
(
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic [rs_depth-1:0]                      slot_valid,
    input  logic [dispatch_width-1:0]                dispatch_valid,
    // one-hot target slot per dispatch lane
    output logic [dispatch_width-1:0][rs_depth-1:0]  dispatch_slot,
    output logic [open_w-1:0]                        open_entries
);

    logic [rs_depth-1:0] avail;
    logic [rs_slot_w:0]  free_count;

    // each lane peels off the lowest slot still free
    always_comb begin
        avail = ~slot_valid;
        for (int lane = 0; lane < dispatch_width; lane++) begin
            dispatch_slot[lane] = avail & (~avail + 1'b1);
            avail = avail & ~dispatch_slot[lane];
        end
    end

    assign free_count = (rs_slot_w + 1)'($countones(~slot_valid));

    // capped at what one cycle can take
    assign open_entries = (free_count > dispatch_width) ? open_w'(dispatch_width)
                                                        : open_w'(free_count);

    // dispatcher honours the open count it read this cycle
    assert property (@(posedge clock) disable iff (reset)
        $countones(dispatch_valid) <= open_entries)
        else $error("dispatch of %0d exceeds open_entries %0d",
                    $countones(dispatch_valid), open_entries);

endmodule

// ==== hdl/rs_entry_array.sv ====
`timescale 1ns/1ps

module rs_entry_array
    import rs_params_pkg::*, rs_types_pkg::*;
(
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic     [dispatch_width-1:0]           dispatch_valid,
    input  fu_kind_t [dispatch_width-1:0]           dispatch_kind,
    input  preg_t    [dispatch_width-1:0]           dispatch_dest,
    input  preg_t    [dispatch_width-1:0]           dispatch_src1,
    input  preg_t    [dispatch_width-1:0]           dispatch_src2,
    input  logic     [dispatch_width-1:0]           dispatch_src1_ready,
    input  logic     [dispatch_width-1:0]           dispatch_src2_ready,
    input  br_mask_t [dispatch_width-1:0]           dispatch_mask,
    input  logic     [dispatch_width-1:0][rs_depth-1:0] dispatch_slot,
    input  logic     [dispatch_width-1:0]           cdb_valid,
    input  preg_t    [dispatch_width-1:0]           cdb_tag,
    input  logic                                    squash,
    input  br_mask_t                                squash_mask,
    input  logic     [num_alu-1:0][rs_depth-1:0]    alu_grant,
    input  logic     [num_mult-1:0][rs_depth-1:0]   mult_grant,
    output logic     [rs_depth-1:0]                 slot_valid,
    output fu_kind_t [rs_depth-1:0]                 slot_kind,
    output logic     [rs_depth-1:0]                 slot_ready,
    output logic     [num_alu-1:0]                  alu_issue_valid,
    output preg_t    [num_alu-1:0]                  alu_issue_dest,
    output preg_t    [num_alu-1:0]                  alu_issue_src1,
    output preg_t    [num_alu-1:0]                  alu_issue_src2,
    output logic     [num_mult-1:0]                 mult_issue_valid,
    output preg_t    [num_mult-1:0]                 mult_issue_dest,
    output preg_t    [num_mult-1:0]                 mult_issue_src1,
    output preg_t    [num_mult-1:0]                 mult_issue_src2
);

    logic     [rs_depth-1:0] valid_q, valid_d;
    logic     [rs_depth-1:0] src1_ready_q, src1_ready_d, src2_ready_q, src2_ready_d;
    fu_kind_t [rs_depth-1:0] kind_q;
    preg_t    [rs_depth-1:0] dest_q, src1_q, src2_q;
    br_mask_t [rs_depth-1:0] mask_q;
    logic     [rs_depth-1:0] slot_squashed, slot_granted;
    logic     [dispatch_width-1:0] lane_write;
    logic     [rs_depth-1:0][num_alu+num_mult-1:0] slot_lanes;

    // any valid result bus lane carrying this tag
    function automatic logic cdb_hit(preg_t tag, logic [dispatch_width-1:0] valid,
                                     preg_t [dispatch_width-1:0] tags);
        logic hit;
        hit = 1'b0;
        for (int j = 0; j < dispatch_width; j++) begin
            hit = hit | (valid[j] && (tags[j] == tag));
        end
        return hit;
    endfunction

    // and-or mux of one slot field under a one-hot grant
    function automatic preg_t select_tag(logic [rs_depth-1:0] sel, preg_t [rs_depth-1:0] tags);
        preg_t result;
        result = '0;
        for (int s = 0; s < rs_depth; s++) begin
            if (sel[s]) result = result | tags[s];
        end
        return result;
    endfunction

    //////////////////////////////////////////////////
    // per slot status
    //////////////////////////////////////////////////

    always_comb begin
        for (int s = 0; s < rs_depth; s++) begin
            slot_squashed[s] = squash && ((mask_q[s] & squash_mask) != '0);
            for (int l = 0; l < num_alu; l++) slot_lanes[s][l] = alu_grant[l][s];
            for (int m = 0; m < num_mult; m++) slot_lanes[s][num_alu+m] = mult_grant[m][s];
            slot_granted[s] = |slot_lanes[s];
        end
        for (int d = 0; d < dispatch_width; d++) begin
            lane_write[d] = dispatch_valid[d] && !(squash && ((dispatch_mask[d] & squash_mask) != '0));
        end
    end

    assign slot_valid = valid_q;
    assign slot_kind = kind_q;
    // squashed entries must not issue in the squash cycle
    assign slot_ready = valid_q & src1_ready_q & src2_ready_q & ~slot_squashed;

    // wakeup, removal, then dispatch writes
    always_comb begin
        valid_d = valid_q & ~slot_squashed & ~slot_granted;
        src1_ready_d = src1_ready_q;
        src2_ready_d = src2_ready_q;
        for (int s = 0; s < rs_depth; s++) begin
            if (cdb_hit(src1_q[s], cdb_valid, cdb_tag)) src1_ready_d[s] = 1'b1;
            if (cdb_hit(src2_q[s], cdb_valid, cdb_tag)) src2_ready_d[s] = 1'b1;
            for (int d = 0; d < dispatch_width; d++) begin
                if (lane_write[d] && dispatch_slot[d][s]) begin
                    valid_d[s] = 1'b1;
                    src1_ready_d[s] = dispatch_src1_ready[d] ||
                                      cdb_hit(dispatch_src1[d], cdb_valid, cdb_tag);
                    src2_ready_d[s] = dispatch_src2_ready[d] ||
                                      cdb_hit(dispatch_src2[d], cdb_valid, cdb_tag);
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    // payload only changes on a dispatch write
    always_ff @(posedge clock) begin
        src1_ready_q <= src1_ready_d;
        src2_ready_q <= src2_ready_d;
        for (int d = 0; d < dispatch_width; d++) begin
            for (int s = 0; s < rs_depth; s++) begin
                if (lane_write[d] && dispatch_slot[d][s]) begin
                    kind_q[s] <= dispatch_kind[d];
                    dest_q[s] <= dispatch_dest[d];
                    src1_q[s] <= dispatch_src1[d];
                    src2_q[s] <= dispatch_src2[d];
                    mask_q[s] <= dispatch_mask[d];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // issue fields
    //////////////////////////////////////////////////

    always_comb begin
        for (int l = 0; l < num_alu; l++) begin
            alu_issue_valid[l] = |alu_grant[l];
            alu_issue_dest[l] = select_tag(alu_grant[l], dest_q);
            alu_issue_src1[l] = select_tag(alu_grant[l], src1_q);
            alu_issue_src2[l] = select_tag(alu_grant[l], src2_q);
        end
        for (int m = 0; m < num_mult; m++) begin
            mult_issue_valid[m] = |mult_grant[m];
            mult_issue_dest[m] = select_tag(mult_grant[m], dest_q);
            mult_issue_src1[m] = select_tag(mult_grant[m], src1_q);
            mult_issue_src2[m] = select_tag(mult_grant[m], src2_q);
        end
    end

    // the alu and mult selectors never claim the same slot
    for (genvar s = 0; s < rs_depth; s++) begin : g_slot_check
        assert property (@(posedge clock) disable iff (reset) $onehot0(slot_lanes[s]))
            else $error("slot %0d granted to more than one lane", s);
    end

    // every valid dispatch lane lands in exactly one empty slot
    for (genvar d = 0; d < dispatch_width; d++) begin : g_dispatch_check
        assert property (@(posedge clock) disable iff (reset)
            dispatch_valid[d] |->
                ($onehot(dispatch_slot[d]) && ((dispatch_slot[d] & valid_q) == '0)))
            else $error("dispatch lane %0d has no empty target slot", d);
    end

endmodule

// ==== hdl/rs_station.sv ====
`timescale 1ns/1ps

module rs_station
    import rs_params_pkg::*, rs_types_pkg::*;
(
    input  logic                                    clock,
    input  logic                                    reset,

    // dispatch lanes
    input  logic     [dispatch_width-1:0]           dispatch_valid,
    input  fu_kind_t [dispatch_width-1:0]           dispatch_kind,
    input  preg_t    [dispatch_width-1:0]           dispatch_dest,
    input  preg_t    [dispatch_width-1:0]           dispatch_src1,
    input  preg_t    [dispatch_width-1:0]           dispatch_src2,
    input  logic     [dispatch_width-1:0]           dispatch_src1_ready,
    input  logic     [dispatch_width-1:0]           dispatch_src2_ready,
    input  br_mask_t [dispatch_width-1:0]           dispatch_mask,
    output logic     [open_w-1:0]                   open_entries,

    // result bus
    input  logic     [dispatch_width-1:0]           cdb_valid,
    input  preg_t    [dispatch_width-1:0]           cdb_tag,

    // mispredict recovery
    input  logic                                    squash,
    input  br_mask_t                                squash_mask,

    // functional units
    input  logic     [num_alu-1:0]                  alu_busy,
    input  logic     [num_mult-1:0]                 mult_busy,
    output logic     [num_alu-1:0]                  alu_issue_valid,
    output preg_t    [num_alu-1:0]                  alu_issue_dest,
    output preg_t    [num_alu-1:0]                  alu_issue_src1,
    output preg_t    [num_alu-1:0]                  alu_issue_src2,
    output logic     [num_mult-1:0]                 mult_issue_valid,
    output preg_t    [num_mult-1:0]                 mult_issue_dest,
    output preg_t    [num_mult-1:0]                 mult_issue_src1,
    output preg_t    [num_mult-1:0]                 mult_issue_src2
);

    logic     [rs_depth-1:0]                      slot_valid;
    fu_kind_t [rs_depth-1:0]                      slot_kind;
    logic     [rs_depth-1:0]                      slot_ready;
    logic     [dispatch_width-1:0][rs_depth-1:0]  dispatch_slot;
    logic     [rs_depth-1:0]                      alu_request;
    logic     [rs_depth-1:0]                      mult_request;
    logic     [num_alu-1:0][rs_depth-1:0]         alu_grant;
    logic     [num_mult-1:0][rs_depth-1:0]        mult_grant;

    // split ready slots by unit class
    always_comb begin
        for (int s = 0; s < rs_depth; s++) begin
            alu_request[s] = slot_ready[s] && (slot_kind[s] == fu_alu);
            mult_request[s] = slot_ready[s] && (slot_kind[s] == fu_mult);
        end
    end

    rs_entry_array entry_array (
        .clock, .reset,
        .dispatch_valid, .dispatch_kind, .dispatch_dest, .dispatch_src1, .dispatch_src2,
        .dispatch_src1_ready, .dispatch_src2_ready, .dispatch_mask, .dispatch_slot,
        .cdb_valid, .cdb_tag, .squash, .squash_mask, .alu_grant, .mult_grant,
        .slot_valid, .slot_kind, .slot_ready,
        .alu_issue_valid, .alu_issue_dest, .alu_issue_src1, .alu_issue_src2,
        .mult_issue_valid, .mult_issue_dest, .mult_issue_src1, .mult_issue_src2
    );

    rs_free_select free_select (
        .clock, .reset, .slot_valid, .dispatch_valid, .dispatch_slot, .open_entries
    );

    rs_issue_select #(.num_lanes(num_alu)) alu_select (
        .clock, .reset, .request(alu_request), .busy(alu_busy), .grant(alu_grant)
    );

    rs_issue_select #(.num_lanes(num_mult)) mult_select (
        .clock, .reset, .request(mult_request), .busy(mult_busy), .grant(mult_grant)
    );

endmodule

// ==== bench/rs_ref_model.svh ====
//////////////////////////////////////////////////
// window model, one entry per slot
//////////////////////////////////////////////////

logic     model_valid [rs_depth];
fu_kind_t model_kind [rs_depth];
preg_t    model_dest [rs_depth];
preg_t    model_src1 [rs_depth];
preg_t    model_src2 [rs_depth];
logic     model_rdy1 [rs_depth];
logic     model_rdy2 [rs_depth];
br_mask_t model_mask [rs_depth];
logic     slot_taken [rs_depth];

// granted slot per unit lane, -1 when idle
int alu_slot [num_alu];
int mult_slot [num_mult];

function automatic logic squashed_by(br_mask_t mask);
    return squash && ((mask & squash_mask) != '0);
endfunction

// tag seen on any valid result bus lane this cycle
function automatic logic woken(preg_t tag);
    logic hit;
    hit = 1'b0;
    for (int j = 0; j < dispatch_width; j++) begin
        if (cdb_valid[j] && (cdb_tag[j] == tag)) begin
            hit = 1'b1;
        end
    end
    return hit;
endfunction

function automatic int open_in_model();
    int free;
    free = 0;
    for (int s = 0; s < rs_depth; s++) begin
        if (!model_valid[s]) begin
            free++;
        end
    end
    return (free > dispatch_width) ? dispatch_width : free;
endfunction

task automatic reset_model();
    for (int s = 0; s < rs_depth; s++) begin
        model_valid[s] = 1'b0;
    end
endtask

// lowest ready slot of one class not claimed by a lower lane
function automatic int lowest_ready(fu_kind_t kind);
    for (int s = 0; s < rs_depth; s++) begin
        if (model_valid[s] && model_rdy1[s] && model_rdy2[s] && (model_kind[s] == kind) &&
            !squashed_by(model_mask[s]) && !slot_taken[s]) begin
            slot_taken[s] = 1'b1;
            return s;
        end
    end
    return -1;
endfunction

task automatic predict_issue();
    for (int s = 0; s < rs_depth; s++) begin
        slot_taken[s] = 1'b0;
    end
    for (int l = 0; l < num_alu; l++) begin
        alu_slot[l] = alu_busy[l] ? -1 : lowest_ready(fu_alu);
    end
    for (int m = 0; m < num_mult; m++) begin
        mult_slot[m] = mult_busy[m] ? -1 : lowest_ready(fu_mult);
    end
endtask

// clock edge, with the inputs of the cycle that ends here
task automatic advance_model();
    int target [dispatch_width];
    int found;
    found = 0;
    for (int d = 0; d < dispatch_width; d++) begin
        target[d] = -1;
    end
    // free slots as seen before this edge's removals
    for (int s = 0; s < rs_depth; s++) begin
        if (!model_valid[s] && (found < dispatch_width)) begin
            target[found] = s;
            found++;
        end
    end
    for (int l = 0; l < num_alu; l++) begin
        if (alu_slot[l] >= 0) model_valid[alu_slot[l]] = 1'b0;
    end
    for (int m = 0; m < num_mult; m++) begin
        if (mult_slot[m] >= 0) model_valid[mult_slot[m]] = 1'b0;
    end
    for (int s = 0; s < rs_depth; s++) begin
        if (model_valid[s]) begin
            if (squashed_by(model_mask[s])) model_valid[s] = 1'b0;
            if (woken(model_src1[s])) model_rdy1[s] = 1'b1;
            if (woken(model_src2[s])) model_rdy2[s] = 1'b1;
        end
    end
    for (int d = 0; d < dispatch_width; d++) begin
        if (dispatch_valid[d] && !squashed_by(dispatch_mask[d])) begin
            if (target[d] < 0) begin
                $display("dispatch lane %0d found no free slot in the model", d);
                errors++;
            end else begin
                model_valid[target[d]] = 1'b1;
                model_kind[target[d]] = dispatch_kind[d];
                model_dest[target[d]] = dispatch_dest[d];
                model_src1[target[d]] = dispatch_src1[d];
                model_src2[target[d]] = dispatch_src2[d];
                model_rdy1[target[d]] = dispatch_src1_ready[d] || woken(dispatch_src1[d]);
                model_rdy2[target[d]] = dispatch_src2_ready[d] || woken(dispatch_src2[d]);
                model_mask[target[d]] = dispatch_mask[d];
            end
        end
    end
endtask

// ==== bench/rs_station_tb.sv ====
`timescale 1ns/1ps

module rs_station_tb
    import rs_params_pkg::*, rs_types_pkg::*;
();

    localparam int reset_cycles = 5;
    localparam int directed_cycles = 150;
    localparam int random_cycles = 2000;
    localparam int cycle_limit = reset_cycles + 4 * directed_cycles + random_cycles + 400;

    logic clock = 1'b0;
    logic reset;
    logic     [dispatch_width-1:0] dispatch_valid, dispatch_src1_ready, dispatch_src2_ready;
    fu_kind_t [dispatch_width-1:0] dispatch_kind;
    preg_t    [dispatch_width-1:0] dispatch_dest, dispatch_src1, dispatch_src2;
    br_mask_t [dispatch_width-1:0] dispatch_mask;
    logic     [open_w-1:0]         open_entries;
    logic     [dispatch_width-1:0] cdb_valid;
    preg_t    [dispatch_width-1:0] cdb_tag;
    logic                          squash;
    br_mask_t                      squash_mask;
    logic     [num_alu-1:0]        alu_busy, alu_issue_valid;
    preg_t    [num_alu-1:0]        alu_issue_dest, alu_issue_src1, alu_issue_src2;
    logic     [num_mult-1:0]       mult_busy, mult_issue_valid;
    preg_t    [num_mult-1:0]       mult_issue_dest, mult_issue_src1, mult_issue_src2;

    integer seed;
    int checks = 0;
    int errors = 0;
    int cycle_count = 0;

    `include "rs_ref_model.svh"

    rs_station rs_station_i (.*);

    always #50 clock = ~clock;

    // run limit
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout, run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("CHECK FAILED %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic check_lane(input string unit, input int lane, input int slot,
                              input logic valid, input preg_t dest, input preg_t src1,
                              input preg_t src2);
        check_value($sformatf("%s_issue_valid[%0d]", unit, lane), valid, slot >= 0);
        if (slot >= 0) begin
            check_value($sformatf("%s_issue_dest[%0d]", unit, lane), dest, model_dest[slot]);
            check_value($sformatf("%s_issue_src1[%0d]", unit, lane), src1, model_src1[slot]);
            check_value($sformatf("%s_issue_src2[%0d]", unit, lane), src2, model_src2[slot]);
        end
    endtask

    task automatic compare_outputs();
        predict_issue();
        check_value("open_entries", open_entries, open_in_model());
        for (int l = 0; l < num_alu; l++) begin
            check_lane("alu", l, alu_slot[l], alu_issue_valid[l], alu_issue_dest[l],
                       alu_issue_src1[l], alu_issue_src2[l]);
        end
        for (int m = 0; m < num_mult; m++) begin
            check_lane("mult", m, mult_slot[m], mult_issue_valid[m], mult_issue_dest[m],
                       mult_issue_src1[m], mult_issue_src2[m]);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    function automatic logic chance(int pct);
        return ({$random(seed)} % 100) < pct;
    endfunction

    task automatic drive_inputs(input int ready_pct, input int tag_range, input int cdb_pct,
                                input int busy_pct, input int squash_pct);
        logic     [dispatch_width-1:0] valid_v, rdy1_v, rdy2_v, cdb_v;
        fu_kind_t [dispatch_width-1:0] kind_v;
        preg_t    [dispatch_width-1:0] dest_v, src1_v, src2_v, tag_v;
        br_mask_t [dispatch_width-1:0] mask_v;
        logic     [num_alu-1:0]        alu_v;
        logic     [num_mult-1:0]       mult_v;
        int count;
        // lanes fill from lane 0 up, never past the open count
        count = {$random(seed)} % (open_in_model() + 1);
        for (int d = 0; d < dispatch_width; d++) begin
            valid_v[d] = d < count;
            kind_v[d] = chance(50) ? fu_mult : fu_alu;
            dest_v[d] = preg_t'({$random(seed)} % tag_range);
            src1_v[d] = preg_t'({$random(seed)} % tag_range);
            src2_v[d] = preg_t'({$random(seed)} % tag_range);
            rdy1_v[d] = chance(ready_pct);
            rdy2_v[d] = chance(ready_pct);
            mask_v[d] = br_mask_t'($random(seed));
            cdb_v[d] = chance(cdb_pct);
            tag_v[d] = preg_t'({$random(seed)} % tag_range);
        end
        for (int l = 0; l < num_alu; l++) begin
            alu_v[l] = chance(busy_pct);
        end
        for (int m = 0; m < num_mult; m++) begin
            mult_v[m] = chance(busy_pct);
        end
        dispatch_valid <= valid_v;
        dispatch_kind <= kind_v;
        dispatch_dest <= dest_v;
        dispatch_src1 <= src1_v;
        dispatch_src2 <= src2_v;
        dispatch_src1_ready <= rdy1_v;
        dispatch_src2_ready <= rdy2_v;
        dispatch_mask <= mask_v;
        cdb_valid <= cdb_v;
        cdb_tag <= tag_v;
        alu_busy <= alu_v;
        mult_busy <= mult_v;
        squash <= chance(squash_pct);
        squash_mask <= br_mask_t'(1 << ({$random(seed)} % br_mask_w));
    endtask

    // outputs checked mid cycle, model stepped at the edge
    task automatic run_test(input string name, input int cycles, input int ready_pct,
                            input int tag_range, input int cdb_pct, input int busy_pct,
                            input int squash_pct);
        int errors_before;
        errors_before = errors;
        repeat (cycles) begin
            @(negedge clock);
            compare_outputs();
            @(posedge clock);
            advance_model();
            drive_inputs(ready_pct, tag_range, cdb_pct, busy_pct, squash_pct);
        end
        $display("test %-8s %5d cycles, %0d errors", name, cycles, errors - errors_before);
    endtask

    initial begin
        seed = 82265;
        reset = 1'b1;
        dispatch_valid = '0;
        dispatch_kind = {dispatch_width{fu_none}};
        dispatch_dest = '0;
        dispatch_src1 = '0;
        dispatch_src2 = '0;
        dispatch_src1_ready = '0;
        dispatch_src2_ready = '0;
        dispatch_mask = '0;
        cdb_valid = '0;
        cdb_tag = '0;
        squash = 1'b0;
        squash_mask = '0;
        alu_busy = '0;
        mult_busy = '0;
        reset_model();
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        run_test("reset", 1, 100, 64, 0, 0, 0);
        run_test("issue", directed_cycles, 100, 64, 0, 0, 0);
        run_test("wakeup", directed_cycles, 30, 16, 60, 0, 0);
        // units held long enough to fill the window, then released
        run_test("busy", directed_cycles - 50, 80, 64, 30, 100, 0);
        run_test("drain", 50, 80, 64, 30, 0, 0);
        run_test("squash", directed_cycles, 70, 64, 50, 30, 15);
        run_test("random", random_cycles, 50, 32, 50, 25, 5);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+bench
hdl/rs_params_pkg.sv
hdl/rs_types_pkg.sv
hdl/rs_issue_select.sv
hdl/rs_free_select.sv
hdl/rs_entry_array.sv
hdl/rs_station.sv
bench/rs_station_tb.sv
